//--- gat_conv_pkg.sv
package gat_conv_pkg;

  // Feature and weight sizes
  localparam int DATA_WIDTH      = 8;
  localparam int NUM_FEATURE_IN  = 16;
  localparam int NUM_FEATURE_OUT = 4;
  localparam int MAX_NODES       = 8;
  localparam int COL_IDX_WIDTH   = $clog2(NUM_FEATURE_IN);
  localparam int NUM_NODE_WIDTH  = $clog2(MAX_NODES);
  localparam int OUT_IDX_WIDTH   = $clog2(NUM_FEATURE_OUT);
  localparam int WH_DATA_WIDTH   = 20;

  // Weight address map, W first and then a
  localparam int W_SIZE          = NUM_FEATURE_IN * NUM_FEATURE_OUT;
  localparam int A_DEPTH         = 2 * NUM_FEATURE_OUT;
  localparam int A_IDX_WIDTH     = $clog2(A_DEPTH);
  localparam int WEIGHT_DEPTH    = W_SIZE + A_DEPTH;
  localparam int WEIGHT_ADDR_W   = $clog2(WEIGHT_DEPTH);

  // Product widths
  localparam int H_PROD_WIDTH    = 2 * DATA_WIDTH;
  localparam int A_PROD_WIDTH    = WH_DATA_WIDTH + DATA_WIDTH;

  // Attention
  localparam int COEF_WIDTH      = 32;
  localparam int LEAKY_SHIFT     = 3;

  // Coefficient FIFO
  localparam int COEF_DEPTH      = 16;
  localparam int FIFO_SLACK      = 6;
  localparam int FIFO_PTR_W      = $clog2(COEF_DEPTH);

  typedef struct packed {
    logic signed [DATA_WIDTH-1:0] value;
    logic [COL_IDX_WIDTH-1:0]     col;
    logic                         row_last;
    logic                         graph_last;
  } h_entry_t;

  typedef struct packed {
    logic [NUM_FEATURE_OUT-1:0][WH_DATA_WIDTH-1:0] feat;
    logic [NUM_NODE_WIDTH-1:0]                     node;
    logic                                          graph_last;
  } wh_row_t;

  typedef struct packed {
    logic signed [COEF_WIDTH-1:0] value;
    logic [NUM_NODE_WIDTH-1:0]    node;
    logic                         graph_last;
  } coef_t;

endpackage

//--- weight_store.sv
`timescale 1ns/100ps

module weight_store
  import gat_conv_pkg::*;
(
  input  logic                                       clk,
  input  logic                                       rst_n,
  input  logic                                       wgt_wr_i,
  input  logic [WEIGHT_ADDR_W-1:0]                   wgt_addr_i,
  input  logic [DATA_WIDTH-1:0]                      wgt_data_i,
  input  logic                                       wgt_load_done_i,
  input  logic [COL_IDX_WIDTH-1:0]                   col_i,
  output logic [NUM_FEATURE_OUT-1:0][DATA_WIDTH-1:0] w_row_o,
  output logic [A_DEPTH-1:0][DATA_WIDTH-1:0]         a_o,
  output logic                                       w_rdy_o
);

  logic [NUM_FEATURE_OUT-1:0][DATA_WIDTH-1:0] w_mem [NUM_FEATURE_IN];
  logic [A_DEPTH-1:0][DATA_WIDTH-1:0]         a_reg;
  logic                                       w_region;
  logic                                       a_region;
  logic [COL_IDX_WIDTH-1:0]                   w_row_sel;
  logic [OUT_IDX_WIDTH-1:0]                   w_feat_sel;
  logic [WEIGHT_ADDR_W-1:0]                   a_offset;

  // Address decode
  assign w_region   = wgt_addr_i < WEIGHT_ADDR_W'(W_SIZE);
  assign a_region   = !w_region && (wgt_addr_i < WEIGHT_ADDR_W'(WEIGHT_DEPTH));
  assign w_row_sel  = wgt_addr_i[OUT_IDX_WIDTH +: COL_IDX_WIDTH];
  assign w_feat_sel = wgt_addr_i[OUT_IDX_WIDTH-1:0];
  assign a_offset   = wgt_addr_i - WEIGHT_ADDR_W'(W_SIZE);

  always_ff @(posedge clk) begin
    if (wgt_wr_i && w_region) begin
      w_mem[w_row_sel][w_feat_sel] <= wgt_data_i;
    end
    if (wgt_wr_i && a_region) begin
      a_reg[a_offset[A_IDX_WIDTH-1:0]] <= wgt_data_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      w_rdy_o <= 1'b0;
    end else begin
      w_rdy_o <= wgt_load_done_i;
    end
  end

  // W row for the column of the current H entry
  assign w_row_o = w_mem[col_i];
  assign a_o     = a_reg;

endmodule

//--- spmm.sv
`timescale 1ns/100ps

module spmm
  import gat_conv_pkg::*;
(
  input  logic                                       clk,
  input  logic                                       rst_n,
  input  logic                                       h_vld_i,
  input  h_entry_t                                   h_entry_i,
  output logic                                       h_rdy_o,
  input  logic                                       w_rdy_i,
  input  logic                                       almost_full_i,
  output logic [COL_IDX_WIDTH-1:0]                   col_o,
  input  logic [NUM_FEATURE_OUT-1:0][DATA_WIDTH-1:0] w_row_i,
  output logic                                       wh_vld_o,
  output wh_row_t                                    wh_row_o
);

  logic                                          accept;
  logic                                          row_done;
  logic [NUM_NODE_WIDTH-1:0]                     node_cnt;
  logic [NUM_FEATURE_OUT-1:0][H_PROD_WIDTH-1:0]  prod;
  logic [NUM_FEATURE_OUT-1:0][WH_DATA_WIDTH-1:0] acc;
  logic [NUM_FEATURE_OUT-1:0][WH_DATA_WIDTH-1:0] acc_next;

  // Stall input once weights are missing or the FIFO fills up
  assign h_rdy_o  = w_rdy_i && !almost_full_i;
  assign accept   = h_vld_i && h_rdy_o;
  assign row_done = accept && h_entry_i.row_last;
  assign col_o    = h_entry_i.col;

  always_comb begin
    for (int k = 0; k < NUM_FEATURE_OUT; k++) begin
      prod[k]     = $signed(h_entry_i.value) * $signed(w_row_i[k]);
      acc_next[k] = $signed(acc[k]) + $signed(prod[k]);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc      <= '0;
      node_cnt <= '0;
      wh_vld_o <= 1'b0;
    end else begin
      wh_vld_o <= row_done;
      if (row_done) begin
        acc <= '0;
        // Node index restarts with each subgraph
        if (h_entry_i.graph_last) begin
          node_cnt <= '0;
        end else begin
          node_cnt <= node_cnt + 1'b1;
        end
      end else if (accept) begin
        acc <= acc_next;
      end
    end
  end

  // Last entry of the row is folded in on the way out
  always_ff @(posedge clk) begin
    if (row_done) begin
      wh_row_o.feat       <= acc_next;
      wh_row_o.node       <= node_cnt;
      wh_row_o.graph_last <= h_entry_i.graph_last;
    end
  end

endmodule

//--- dmvm.sv
`timescale 1ns/100ps

module dmvm
  import gat_conv_pkg::*;
(
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               wh_vld_i,
  input  wh_row_t                            wh_row_i,
  input  logic [A_DEPTH-1:0][DATA_WIDTH-1:0] a_i,
  output logic                               push_o,
  output coef_t                              coef_o
);

  logic                           s1_vld;
  logic [NUM_NODE_WIDTH-1:0]      s1_node;
  logic                           s1_last;
  logic signed [A_PROD_WIDTH-1:0] prod_first [NUM_FEATURE_OUT];
  logic signed [A_PROD_WIDTH-1:0] prod_own [NUM_FEATURE_OUT];

  logic signed [COEF_WIDTH-1:0]   sum_first;
  logic signed [COEF_WIDTH-1:0]   sum_own;
  logic                           s2_vld;
  logic [NUM_NODE_WIDTH-1:0]      s2_node;
  logic                           s2_last;
  logic signed [COEF_WIDTH-1:0]   s2_sum_first;
  logic signed [COEF_WIDTH-1:0]   s2_sum_own;

  logic signed [COEF_WIDTH-1:0]   first_score;
  logic signed [COEF_WIDTH-1:0]   first_sel;
  logic signed [COEF_WIDTH-1:0]   score;
  logic signed [COEF_WIDTH-1:0]   leaky;

  // Stage 1, products with both halves of a
  always_ff @(posedge clk) begin
    if (wh_vld_i) begin
      for (int k = 0; k < NUM_FEATURE_OUT; k++) begin
        prod_first[k] <= $signed(wh_row_i.feat[k]) * $signed(a_i[k]);
        prod_own[k]   <= $signed(wh_row_i.feat[k]) * $signed(a_i[NUM_FEATURE_OUT + k]);
      end
      s1_node <= wh_row_i.node;
      s1_last <= wh_row_i.graph_last;
    end
  end

  always_comb begin
    sum_first = '0;
    sum_own   = '0;
    for (int k = 0; k < NUM_FEATURE_OUT; k++) begin
      sum_first = sum_first + prod_first[k];
      sum_own   = sum_own + prod_own[k];
    end
  end

  // Stage 2, dot sums
  always_ff @(posedge clk) begin
    if (s1_vld) begin
      s2_sum_first <= sum_first;
      s2_sum_own   <= sum_own;
      s2_node      <= s1_node;
      s2_last      <= s1_last;
    end
  end

  // Node 0 uses its own first-half score before it is stored
  assign first_sel = (s2_node == '0) ? s2_sum_first : first_score;
  assign score     = first_sel + s2_sum_own;
  assign leaky     = score[COEF_WIDTH-1] ? (score >>> LEAKY_SHIFT) : score;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_vld      <= 1'b0;
      s2_vld      <= 1'b0;
      push_o      <= 1'b0;
      first_score <= '0;
    end else begin
      s1_vld <= wh_vld_i;
      s2_vld <= s1_vld;
      push_o <= s2_vld;
      if (s2_vld && (s2_node == '0)) begin
        first_score <= s2_sum_first;
      end
    end
  end

  // Stage 3, coefficient out to the FIFO
  always_ff @(posedge clk) begin
    if (s2_vld) begin
      coef_o.value      <= leaky;
      coef_o.node       <= s2_node;
      coef_o.graph_last <= s2_last;
    end
  end

endmodule

//--- coef_fifo.sv
`timescale 1ns/100ps

module coef_fifo
  import gat_conv_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  push_i,
  input  coef_t coef_i,
  input  logic  rd_i,
  output coef_t coef_o,
  output logic  empty_o,
  output logic  almost_full_o
);

  coef_t                 mem [COEF_DEPTH];
  logic [FIFO_PTR_W-1:0] wr_ptr;
  logic [FIFO_PTR_W-1:0] rd_ptr;
  logic [FIFO_PTR_W:0]   count;
  logic                  wr_en;
  logic                  rd_en;

  assign wr_en         = push_i && (count != (FIFO_PTR_W + 1)'(COEF_DEPTH));
  assign rd_en         = rd_i && !empty_o;
  assign empty_o       = (count == '0);
  assign almost_full_o = count > (FIFO_PTR_W + 1)'(COEF_DEPTH - FIFO_SLACK);

  // Show-ahead head
  assign coef_o = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= coef_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- gat_conv.sv
`timescale 1ns/100ps

module gat_conv
  import gat_conv_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     wgt_wr_i,
  input  logic [WEIGHT_ADDR_W-1:0] wgt_addr_i,
  input  logic [DATA_WIDTH-1:0]    wgt_data_i,
  input  logic                     wgt_load_done_i,
  input  logic                     h_vld_i,
  input  h_entry_t                 h_entry_i,
  output logic                     h_rdy_o,
  input  logic                     coef_rd_i,
  output coef_t                    coef_o,
  output logic                     coef_empty_o
);

  logic [COL_IDX_WIDTH-1:0]                   col;
  logic [NUM_FEATURE_OUT-1:0][DATA_WIDTH-1:0] w_row;
  logic [A_DEPTH-1:0][DATA_WIDTH-1:0]         a_vec;
  logic                                       w_rdy;
  logic                                       almost_full;
  logic                                       wh_vld;
  wh_row_t                                    wh_row;
  logic                                       coef_push;
  coef_t                                      coef_new;

  weight_store u_weight_store (
    .clk             (clk),
    .rst_n           (rst_n),
    .wgt_wr_i        (wgt_wr_i),
    .wgt_addr_i      (wgt_addr_i),
    .wgt_data_i      (wgt_data_i),
    .wgt_load_done_i (wgt_load_done_i),
    .col_i           (col),
    .w_row_o         (w_row),
    .a_o             (a_vec),
    .w_rdy_o         (w_rdy)
  );

  spmm u_spmm (
    .clk           (clk),
    .rst_n         (rst_n),
    .h_vld_i       (h_vld_i),
    .h_entry_i     (h_entry_i),
    .h_rdy_o       (h_rdy_o),
    .w_rdy_i       (w_rdy),
    .almost_full_i (almost_full),
    .col_o         (col),
    .w_row_i       (w_row),
    .wh_vld_o      (wh_vld),
    .wh_row_o      (wh_row)
  );

  dmvm u_dmvm (
    .clk      (clk),
    .rst_n    (rst_n),
    .wh_vld_i (wh_vld),
    .wh_row_i (wh_row),
    .a_i      (a_vec),
    .push_o   (coef_push),
    .coef_o   (coef_new)
  );

  coef_fifo u_coef_fifo (
    .clk           (clk),
    .rst_n         (rst_n),
    .push_i        (coef_push),
    .coef_i        (coef_new),
    .rd_i          (coef_rd_i),
    .coef_o        (coef_o),
    .empty_o       (coef_empty_o),
    .almost_full_o (almost_full)
  );

endmodule

//--- gat_conv_assert.sv
`timescale 1ns/100ps

module gat_conv_assert (
  input logic clk,
  input logic rst_n,
  input logic wgt_load_done_i,
  input logic h_rdy_o,
  input logic coef_empty_o
);

  int fail_count = 0;

  // No H entries before the weights are marked loaded
  assert property (@(posedge clk) disable iff (!rst_n) !wgt_load_done_i |=> !h_rdy_o)
    else begin
      fail_count++;
      $error("h_rdy_o high one cycle after wgt_load_done_i was low");
    end

  assert property (@(posedge clk) $rose(rst_n) |-> coef_empty_o)
    else begin
      fail_count++;
      $error("coef_empty_o low right after reset");
    end

  // Pipeline is four deep, so a coefficient needs an accepted entry
  assert property (@(posedge clk) disable iff (!rst_n)
                   (!h_rdy_o)[*5] ##0 coef_empty_o |=> coef_empty_o)
    else begin
      fail_count++;
      $error("coefficient appeared without an accepted H entry");
    end

endmodule

bind gat_conv gat_conv_assert u_gat_conv_assert (
  .clk             (clk),
  .rst_n           (rst_n),
  .wgt_load_done_i (wgt_load_done_i),
  .h_rdy_o         (h_rdy_o),
  .coef_empty_o    (coef_empty_o)
);

//--- tb_gat_conv.sv
`timescale 1ns/100ps

module tb_gat_conv;
  import gat_conv_pkg::*;

  typedef struct packed {
    int tid;
    int addr;
    int data;
  } wr_rec_t;

  typedef struct packed {
    int tid;
    int value;
    int col;
    int row_last;
    int graph_last;
    int coef;
    int node;
  } h_rec_t;

  logic                     clk;
  logic                     rst_n;
  logic                     wgt_wr_i;
  logic [WEIGHT_ADDR_W-1:0] wgt_addr_i;
  logic [DATA_WIDTH-1:0]    wgt_data_i;
  logic                     wgt_load_done_i;
  logic                     h_vld_i;
  h_entry_t                 h_entry_i;
  logic                     h_rdy_o;
  logic                     coef_rd_i;
  coef_t                    coef_o;
  logic                     coef_empty_o;

  string   test_name [$];
  int      test_reps [$];
  int      test_hold [$];
  wr_rec_t wr_q [$];
  h_rec_t  h_q [$];
  int      errors;
  int      checks;
  int      failed_tests;
  int      total_h;

  gat_conv gat_conv_i (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic read_vectors();
    int      fd;
    int      n;
    int      v [6];
    string   line;
    string   kw;
    string   name;
    fd = $fopen("gat_conv_testdata.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Cannot open gat_conv_testdata.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n == 0 || line.len() < 2 || line.getc(0) == "#") continue;
        case (line.getc(0))
          "T": begin
            n = $sscanf(line, "%s %s %d %d", kw, name, v[0], v[1]);
            test_name.push_back(name);
            test_reps.push_back(v[0]);
            test_hold.push_back(v[1]);
          end
          "W": begin
            n = $sscanf(line, "%s %d %d %d %d", kw, v[0], v[1], v[2], v[3]);
            wr_q.push_back('{test_name.size() - 1, v[0], v[1]});
            if (n == 5) begin
              wr_q.push_back('{test_name.size() - 1, v[2], v[3]});
            end
          end
          "H": begin
            n = $sscanf(line, "%s %d %d %d %d %d %d",
                        kw, v[0], v[1], v[2], v[3], v[4], v[5]);
            h_q.push_back('{test_name.size() - 1, v[0], v[1], v[2], v[3], v[4], v[5]});
          end
          default: $display("Unknown line in gat_conv_testdata.txt: %s", line);
        endcase
      end
      $fclose(fd);
    end
  endtask

  // Dummy entry stays valid so any early acceptance would show up
  task automatic write_word(int addr, int data);
    wgt_wr_i   = 1'b1;
    wgt_addr_i = WEIGHT_ADDR_W'(addr);
    wgt_data_i = DATA_WIDTH'(data);
    h_vld_i    = 1'b1;
    h_entry_i  = '{DATA_WIDTH'(1), COL_IDX_WIDTH'(0), 1'b1, 1'b0};
    checks++;
    assert (!h_rdy_o && coef_empty_o) else begin
      errors++;
      $error("h_rdy_o high or a coefficient present while the weights are loading");
    end
    next_cycle();
  endtask

  task automatic feed_rows(int tid);
    int gap;
    for (int r = 0; r < test_reps[tid]; r++) begin
      foreach (h_q[i]) begin
        if (h_q[i].tid == tid) begin
          gap = $urandom % 3;
          repeat (gap) next_cycle();
          h_vld_i   = 1'b1;
          h_entry_i = '{DATA_WIDTH'(h_q[i].value), COL_IDX_WIDTH'(h_q[i].col),
                        h_q[i].row_last[0], h_q[i].graph_last[0]};
          while (!h_rdy_o) next_cycle();
          next_cycle();
          h_vld_i = 1'b0;
        end
      end
    end
  endtask

  task automatic check_coefs(int tid);
    h_rec_t exp_q [$];
    h_rec_t e;
    coef_t  exp_c;
    for (int r = 0; r < test_reps[tid]; r++) begin
      foreach (h_q[i]) begin
        if (h_q[i].tid == tid && h_q[i].row_last != 0) exp_q.push_back(h_q[i]);
      end
    end
    // Reads stay off until the FIFO pushes back on the input
    if (test_hold[tid] != 0) begin
      while (h_rdy_o) next_cycle();
      checks++;
      assert (!coef_empty_o) else begin
        errors++;
        $error("h_rdy_o fell while the coefficient FIFO was empty");
      end
    end
    while (exp_q.size() > 0) begin
      coef_rd_i = 1'b0;
      if (!coef_empty_o && ($urandom % 4 != 0)) begin
        e     = exp_q.pop_front();
        exp_c = '{COEF_WIDTH'(e.coef), NUM_NODE_WIDTH'(e.node), e.graph_last[0]};
        checks++;
        assert (coef_o == exp_c) else begin
          errors++;
          $error("Error: test %s expected %0d node %0d last %0d, actual %0d node %0d last %0d",
                 test_name[tid], exp_c.value, exp_c.node, exp_c.graph_last,
                 coef_o.value, coef_o.node, coef_o.graph_last);
        end
        coef_rd_i = 1'b1;
      end
      next_cycle();
    end
    coef_rd_i = 1'b0;
  endtask

  task automatic run_test(int tid);
    int err_before;
    err_before      = errors;
    wgt_load_done_i = 1'b0;
    next_cycle();
    for (int a = 0; a < WEIGHT_DEPTH; a++) write_word(a, 0);
    foreach (wr_q[i]) begin
      if (wr_q[i].tid == tid) write_word(wr_q[i].addr, wr_q[i].data);
    end
    wgt_wr_i        = 1'b0;
    h_vld_i         = 1'b0;
    wgt_load_done_i = 1'b1;
    next_cycle();
    fork
      feed_rows(tid);
      check_coefs(tid);
    join
    repeat (6) next_cycle();
    checks++;
    assert (coef_empty_o) else begin
      errors++;
      $error("Extra coefficient left in the FIFO after test %s", test_name[tid]);
    end
    if (errors != err_before) failed_tests++;
    $display("%s finished with %0d errors", test_name[tid], errors - err_before);
  endtask

  initial begin
    rst_n           = 1'b0;
    wgt_wr_i        = 1'b0;
    wgt_addr_i      = '0;
    wgt_data_i      = '0;
    wgt_load_done_i = 1'b0;
    h_vld_i         = 1'b0;
    h_entry_i       = '0;
    coef_rd_i       = 1'b0;
    errors          = 0;
    checks          = 0;
    failed_tests    = 0;
    total_h         = 0;
    void'($urandom(32'h993c));
    read_vectors();
    foreach (h_q[i]) total_h += test_reps[h_q[i].tid];
    repeat (10) @(posedge clk);
    #1 rst_n = 1'b1;
    next_cycle();
    for (int t = 0; t < test_name.size(); t++) run_test(t);
    $display("Tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
             test_name.size(), failed_tests, checks, errors,
             gat_conv_i.u_gat_conv_assert.fail_count);
    if (errors == 0 && gat_conv_i.u_gat_conv_assert.fail_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    #1;
    repeat (200 * total_h + 1000) @(posedge clk);
    $display("Timeout after %0d cycles, the DUT stopped making progress", 200 * total_h + 1000);
    $display("Test failed");
    $finish;
  end

endmodule

//--- gat_conv.f
gat_conv_pkg.sv
weight_store.sv
spmm.sv
dmvm.sv
coef_fifo.sv
gat_conv.sv
gat_conv_assert.sv
tb_gat_conv.sv

//--- gat_conv_testdata.txt
# T name repeats hold_reads
# W addr data [addr data], W at in*4+out, a at 64 to 71
# H value col row_last graph_last coef node, coef and node are checked on row_last
T single_pos 1 0
W 0 1 5 2
W 10 3 64 1
W 68 2 69 1
H 3 0 0 0 0 0
H 2 1 1 0 13 0
H 1 0 0 0 0 0
H 5 1 1 0 15 1
H 4 2 1 1 3 2
T neg_score 1 0
W 0 1 5 1
W 64 2 68 -3
W 69 1
H 4 0 1 0 -1 0
H 0 0 1 0 8 1
H 3 0 0 0 0 0
H -12 1 1 1 -2 2
T two_graphs 1 0
W 0 1 5 1
W 64 1 65 1
W 68 1 69 -1
H 5 0 1 0 10 0
H 2 1 1 1 3 1
H 1 1 1 0 0 0
H 6 0 1 0 7 1
H 3 1 1 1 -1 2
T backpressure 4 1
W 0 2 64 1
W 68 1
H 1 0 1 0 4 0
H 2 0 1 0 6 1
H 3 0 1 0 8 2
H 4 0 1 0 10 3
H 5 0 1 1 12 4
